// File: include/net_defs.svh
//////////////////////////////
// stream widths and buffer sizes for the 10G data path
// RX_BUF_DEPTH must be a power of two (ring pointers wrap)
// keep is one bit per data byte
//////////////////////////////
`ifndef NET_DEFS_SVH
`define NET_DEFS_SVH

// 64b words as delivered by the MAC user side
`define NET_DATA_W 64
`define NET_KEEP_W 8

// shortest frame the MAC side gets, in words
`define NET_MIN_WORDS 8

// buffering
`define TX_FIFO_DEPTH 16
`define RX_BUF_DEPTH 32

`endif

// File: rtl/net_pkg.sv
//////////////////////////////
// shared stream word and FSM state types
// widths come from net_defs.svh
//////////////////////////////
`default_nettype none

`include "net_defs.svh"

package net_pkg;

    // one beat of a frame stream
    typedef struct packed {
        logic [`NET_DATA_W-1:0] data;
        logic [`NET_KEEP_W-1:0] keep;  // byte enables, lsb = byte 0
        logic                   last;  // final word of the frame
    } axis_word_t;

    // tx padder
    typedef enum logic [0:0] {
        PAD_PASS,  // user words go straight through
        PAD_FILL   // zero words until minimum length
    } pad_state_e;

    // rx store-and-forward filter
    typedef enum logic [1:0] {
        RX_IDLE,   // between frames
        RX_STORE,  // frame being written into the ring
        RX_DROP    // overflowed, skip rest of frame
    } rx_state_e;

endpackage

`default_nettype wire

// File: rtl/net_reset_hold.sv
//////////////////////////////
// holds the data path in reset until both MAC user resets drop
// core_reset releases two edges later, asserts two edges after either rises
//////////////////////////////
`default_nettype none

module net_reset_hold (
    input  wire logic sys_reset,     // clock
    input  wire logic net_clk,       // async reset, active high
    input  wire logic mac_rx_reset,
    input  wire logic mac_tx_reset,
    output logic      core_reset
);

    logic hold_q;  // first stage

    // two stage shift of the OR of the MAC resets
    always_ff @(posedge sys_reset or posedge net_clk) begin
        if (net_clk) begin
            hold_q     <= 1'b1;
            core_reset <= 1'b1;
        end else begin
            hold_q     <= mac_rx_reset | mac_tx_reset;
            core_reset <= hold_q;
        end
    end

    // release only after both MAC sides were quiet two edges earlier
    a_release_after_mac: assert property (
        @(posedge sys_reset) disable iff (net_clk)
        $fell(core_reset) |-> !$past(mac_rx_reset | mac_tx_reset, 2)
    );

endmodule

`default_nettype wire

// File: rtl/rx_frame_filter.sv
//////////////////////////////
// store-and-forward rx buffer, MAC side has no ready
// bad frames and frames bigger than the free ring are dropped whole
// only fully received good frames are shown to the reader
//////////////////////////////
`default_nettype none

`include "net_defs.svh"

module rx_frame_filter import net_pkg::*; (
    input  wire logic       sys_reset,   // clock
    input  wire logic       net_clk,     // async reset
    input  wire logic       core_reset,
    input  wire logic       in_valid,
    input  wire axis_word_t in_word,
    input  wire logic       in_bad,      // only looked at with last
    output logic            out_valid,
    input  wire logic       out_ready,
    output axis_word_t      out_word
);

    localparam int DEPTH = `RX_BUF_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam int PW    = AW + 1;  // extra wrap bit tells full from empty

    axis_word_t    ring [DEPTH];
    rx_state_e     state;
    logic [PW-1:0] wr_ptr;      // tentative, moves with every stored word
    logic [PW-1:0] commit_ptr;  // end of last good frame
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] used;
    logic          full;
    logic          take;
    logic          pop;

    assign used = wr_ptr - rd_ptr;
    assign full = (used == PW'(DEPTH));
    assign take = in_valid && !core_reset && (state != RX_DROP) && !full;

    // reader sees committed words only
    assign out_valid = !core_reset && (rd_ptr != commit_ptr);
    assign out_word  = ring[rd_ptr[AW-1:0]];
    assign pop       = out_valid && out_ready;

    always_ff @(posedge sys_reset or posedge net_clk) begin
        if (net_clk) begin
            state      <= RX_IDLE;
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
        end else if (core_reset) begin
            state      <= RX_IDLE;  // flush everything
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
        end else begin
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (in_valid) begin
                case (state)
                    RX_IDLE, RX_STORE: begin
                        if (full) begin
                            wr_ptr <= commit_ptr;  // no room, forget partial frame
                            state  <= in_word.last ? RX_IDLE : RX_DROP;
                        end else if (in_word.last) begin
                            if (in_bad) begin
                                wr_ptr <= commit_ptr;  // rewind over bad frame
                            end else begin
                                wr_ptr     <= wr_ptr + 1'b1;
                                commit_ptr <= wr_ptr + 1'b1;  // publish frame
                            end
                            state <= RX_IDLE;
                        end else begin
                            wr_ptr <= wr_ptr + 1'b1;
                            state  <= RX_STORE;
                        end
                    end
                    default: begin
                        if (in_word.last)
                            state <= RX_IDLE;  // end of skipped frame
                    end
                endcase
            end
        end
    end

    // ring storage, payload only
    always_ff @(posedge sys_reset) begin
        if (take)
            ring[wr_ptr[AW-1:0]] <= in_word;
    end

    // reader stays within the committed region
    a_rd_behind_commit: assert property (
        @(posedge sys_reset) disable iff (net_clk)
        PW'(commit_ptr - rd_ptr) <= PW'(DEPTH)
    );

endmodule

`default_nettype wire

// File: rtl/tx_frame_padder.sv
//////////////////////////////
// pads tx frames to NET_MIN_WORDS words
// short last word gets full keep, unused bytes zeroed
// no data register, out follows in combinationally
//////////////////////////////
`default_nettype none

`include "net_defs.svh"

module tx_frame_padder import net_pkg::*; (
    input  wire logic       sys_reset,  // clock
    input  wire logic       net_clk,    // async reset
    input  wire logic       core_reset,
    input  wire logic       in_valid,
    output logic            in_ready,
    input  wire axis_word_t in_word,
    output logic            out_valid,
    input  wire logic       out_ready,
    output axis_word_t      out_word
);

    localparam int MIN = `NET_MIN_WORDS;
    localparam int CW  = $clog2(MIN) + 1;

    pad_state_e    state;
    logic [CW-1:0] cnt;  // words issued in this frame, sticks at MIN-1
    logic          short_last;
    logic          fire;
    axis_word_t    pad_word;
    axis_word_t    fill_word;
    logic [7:0]    frame_len;  // issued words since last, saturating

    assign short_last = in_word.last && (cnt < CW'(MIN - 1));

    // pass word, or the reshaped end of a short frame
    always_comb begin
        pad_word = in_word;
        if (short_last) begin
            pad_word.last = 1'b0;
            pad_word.keep = '1;
            for (int b = 0; b < `NET_KEEP_W; b++) begin
                if (!in_word.keep[b])
                    pad_word.data[8*b +: 8] = 8'h00;  // clear bytes outside keep
            end
        end
    end

    always_comb begin
        fill_word.data = '0;
        fill_word.keep = '1;
        fill_word.last = (cnt == CW'(MIN - 1));  // word that reaches minimum
    end

    assign out_word  = (state == PAD_FILL) ? fill_word : pad_word;
    assign out_valid = !core_reset && ((state == PAD_FILL) || in_valid);
    assign in_ready  = !core_reset && (state == PAD_PASS) && out_ready;  // stalled in fill
    assign fire      = out_valid && out_ready;

    always_ff @(posedge sys_reset or posedge net_clk) begin
        if (net_clk) begin
            state <= PAD_PASS;
            cnt   <= '0;
        end else if (core_reset) begin
            state <= PAD_PASS;
            cnt   <= '0;
        end else if (fire) begin
            case (state)
                PAD_PASS: begin
                    if (short_last) begin
                        cnt   <= cnt + 1'b1;
                        state <= PAD_FILL;
                    end else if (in_word.last) begin
                        cnt <= '0;  // long enough, next frame
                    end else if (cnt != CW'(MIN - 1)) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                PAD_FILL: begin
                    if (fill_word.last) begin
                        cnt   <= '0;
                        state <= PAD_PASS;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // output side word count, kept apart from cnt
    always_ff @(posedge sys_reset or posedge net_clk) begin
        if (net_clk)
            frame_len <= '0;
        else if (core_reset)
            frame_len <= '0;
        else if (fire && out_word.last)
            frame_len <= '0;
        else if (fire && frame_len != '1)
            frame_len <= frame_len + 1'b1;
    end

    // no frame leaves shorter than the minimum
    a_min_length: assert property (
        @(posedge sys_reset) disable iff (net_clk)
        (fire && out_word.last) |-> (frame_len >= 8'(MIN - 1))
    );

endmodule

`default_nettype wire

// File: rtl/axis_word_fifo.sv
//////////////////////////////
// synchronous word FIFO, valid/ready both sides
// at least one cycle through, in_ready low when full
//////////////////////////////
`default_nettype none

module axis_word_fifo import net_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  wire logic       sys_reset,  // clock
    input  wire logic       net_clk,    // async reset
    input  wire logic       core_reset,
    input  wire logic       in_valid,
    output logic            in_ready,
    input  wire axis_word_t in_word,
    output logic            out_valid,
    input  wire logic       out_ready,
    output axis_word_t      out_word
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    axis_word_t    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] fill;  // words held
    logic          push;
    logic          pop;

    assign in_ready  = !core_reset && (fill != CW'(DEPTH));
    assign out_valid = !core_reset && (fill != '0);
    assign out_word  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge sys_reset or posedge net_clk) begin
        if (net_clk) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else if (core_reset) begin
            wr_ptr <= '0;  // drop contents
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            fill <= fill + CW'(push) - CW'(pop);
        end
    end

    always_ff @(posedge sys_reset) begin
        if (push)
            mem[wr_ptr] <= in_word;
    end

    a_no_overfill: assert property (
        @(posedge sys_reset) disable iff (net_clk)
        fill <= CW'(DEPTH)
    );

endmodule

`default_nettype wire

// File: rtl/network_module.sv
//////////////////////////////
// single port 10G user side data path, one clock domain
// rx: MAC words filtered, whole good frames to user
// tx: user frames padded, then buffered towards the MAC
//////////////////////////////
`default_nettype none

`include "net_defs.svh"

module network_module import net_pkg::*; (
    input  wire logic       sys_reset,          // clock
    input  wire logic       net_clk,            // async reset, active high
    input  wire logic       mac_rx_reset,
    input  wire logic       mac_tx_reset,
    output logic            network_init_done,
    input  wire logic       mac_rx_valid,       // no ready on this side
    input  wire axis_word_t mac_rx_word,
    input  wire logic       mac_rx_bad,
    output logic            net_rx_valid,
    input  wire logic       net_rx_ready,
    output axis_word_t      net_rx_word,
    input  wire logic       net_tx_valid,
    output logic            net_tx_ready,
    input  wire axis_word_t net_tx_word,
    output logic            mac_tx_valid,
    input  wire logic       mac_tx_ready,
    output axis_word_t      mac_tx_word
);

    logic       core_reset;
    logic       pad_valid;  // padder to tx fifo
    logic       pad_ready;
    axis_word_t pad_word;

    net_reset_hold reset_hold_i (
        .sys_reset    (sys_reset),
        .net_clk      (net_clk),
        .mac_rx_reset (mac_rx_reset),
        .mac_tx_reset (mac_tx_reset),
        .core_reset   (core_reset)
    );

    assign network_init_done = ~core_reset;

    rx_frame_filter rx_filter_i (
        .sys_reset (sys_reset), .net_clk (net_clk), .core_reset (core_reset),
        .in_valid  (mac_rx_valid), .in_word (mac_rx_word), .in_bad (mac_rx_bad),
        .out_valid (net_rx_valid), .out_ready (net_rx_ready), .out_word (net_rx_word)
    );

    tx_frame_padder tx_padder_i (
        .sys_reset (sys_reset), .net_clk (net_clk), .core_reset (core_reset),
        .in_valid  (net_tx_valid), .in_ready (net_tx_ready), .in_word (net_tx_word),
        .out_valid (pad_valid), .out_ready (pad_ready), .out_word (pad_word)
    );

    axis_word_fifo #(.DEPTH(`TX_FIFO_DEPTH)) tx_fifo_i (
        .sys_reset (sys_reset), .net_clk (net_clk), .core_reset (core_reset),
        .in_valid  (pad_valid), .in_ready (pad_ready), .in_word (pad_word),
        .out_valid (mac_tx_valid), .out_ready (mac_tx_ready), .out_word (mac_tx_word)
    );

endmodule

`default_nettype wire

// File: test/network_module_tb.sv
//////////////////////////////
// testbench for network_module
// one clock, random frames from a fixed seed
// expects a 64b data word (two $urandom per word)
//////////////////////////////
`default_nettype none

`include "net_defs.svh"

module network_module_tb import net_pkg::*; ();

    localparam int MAX_CYCLES = 4000;  // roughly 1000 cycles of traffic, 4x margin

    logic       sys_reset = 1'b0;
    logic       net_clk;
    logic       mac_rx_reset;
    logic       mac_tx_reset;
    logic       network_init_done;
    logic       mac_rx_valid;
    axis_word_t mac_rx_word;
    logic       mac_rx_bad;
    logic       net_rx_valid;
    logic       net_rx_ready = 1'b0;
    axis_word_t net_rx_word;
    logic       net_tx_valid;
    logic       net_tx_ready;
    axis_word_t net_tx_word;
    logic       mac_tx_valid;
    logic       mac_tx_ready = 1'b0;
    axis_word_t mac_tx_word;

    axis_word_t frame_buf [64];  // frame under construction
    axis_word_t rx_q [$];        // expected net_rx words
    axis_word_t tx_q [$];        // expected mac_tx words
    axis_word_t rx_exp;
    axis_word_t tx_exp;
    string      test_name = "none";
    bit         rx_ready_rand = 1'b0;
    bit         tx_ready_rand = 1'b0;
    int         init_checks = 0;
    int         init_errors = 0;
    int         word_checks = 0;
    int         word_errors = 0;
    int         cycles = 0;

    always #10 sys_reset = ~sys_reset;  // period 20

    network_module network_module_i (.*);

    // sink readiness, random or always on
    always @(posedge sys_reset) begin
        net_rx_ready <= rx_ready_rand ? ($urandom_range(0, 3) != 0) : 1'b1;
        mac_tx_ready <= tx_ready_rand ? ($urandom_range(0, 1) != 0) : 1'b1;
    end

    // expected word idx of a transmitted frame of len words
    function automatic axis_word_t padded_word(input int len, input int idx);
        axis_word_t w;
        if (idx < len) begin
            w = frame_buf[idx];
        end else begin
            w.data = '0;  // filler
            w.keep = '1;
            w.last = (idx == `NET_MIN_WORDS - 1);
        end
        if (len < `NET_MIN_WORDS && idx == len - 1) begin
            for (int b = 0; b < `NET_KEEP_W; b++) begin
                if (!w.keep[b])
                    w.data[8*b +: 8] = 8'h00;  // bytes beyond original end
            end
            w.keep = '1;
            w.last = 1'b0;  // frame continues with filler
        end
        return w;
    endfunction

    task automatic build_frame(input int len);
        logic [31:0] r;
        for (int i = 0; i < len; i++) begin
            r = $urandom_range(1, (1 << `NET_KEEP_W) - 1);  // nonzero keep
            frame_buf[i].data = {$urandom, $urandom};
            frame_buf[i].keep = (i == len - 1) ? r[`NET_KEEP_W-1:0] : '1;
            frame_buf[i].last = (i == len - 1);
        end
    endtask

    task automatic wait_drain();
        while (rx_q.size() != 0 || tx_q.size() != 0)
            @(posedge sys_reset);
    endtask

    task automatic expect_init_done(input logic exp);
        @(negedge sys_reset);  // stable between edges
        init_checks++;
        if (network_init_done !== exp) begin
            init_errors++;
            $display("error %s expected %b actual %b", test_name, exp, network_init_done);
        end
        // held data path shows no valid and no tx ready
        if (!exp && (net_tx_ready !== 1'b0 || net_rx_valid !== 1'b0
                     || mac_tx_valid !== 1'b0)) begin
            init_errors++;
            $display("%s: a valid or ready output is high while the data path is held",
                     test_name);
        end
    endtask

    // one MAC rx frame, no ready on this side
    task automatic rx_frame(input int len, input bit bad);
        bit fits;
        fits = (len <= `RX_BUF_DEPTH);
        build_frame(len);
        if (fits) begin
            while (rx_q.size() + len > `RX_BUF_DEPTH)
                @(posedge sys_reset);  // whole frame must fit behind what is queued
        end else begin
            wait_drain();
        end
        if (fits && !bad) begin
            for (int i = 0; i < len; i++)
                rx_q.push_back(frame_buf[i]);  // good frames pass untouched
        end
        for (int i = 0; i < len; i++) begin
            @(posedge sys_reset);
            mac_rx_valid <= 1'b1;
            mac_rx_word  <= frame_buf[i];
            mac_rx_bad   <= bad && (i == len - 1);
        end
        @(posedge sys_reset);
        mac_rx_valid <= 1'b0;
        mac_rx_bad   <= 1'b0;
    endtask

    // one user tx frame, waits on net_tx_ready per word
    task automatic tx_frame(input int len);
        int out_len;
        out_len = (len < `NET_MIN_WORDS) ? `NET_MIN_WORDS : len;
        build_frame(len);
        for (int i = 0; i < out_len; i++)
            tx_q.push_back(padded_word(len, i));
        for (int i = 0; i < len; i++) begin
            @(posedge sys_reset);
            net_tx_valid <= 1'b1;
            net_tx_word  <= frame_buf[i];
            @(negedge sys_reset);
            while (!net_tx_ready) begin
                @(posedge sys_reset);
                @(negedge sys_reset);
            end
        end
        @(posedge sys_reset);
        net_tx_valid <= 1'b0;
    endtask

    // compare every accepted output word, handshake completes on the next edge
    always @(negedge sys_reset) begin
        if (net_rx_valid && net_rx_ready) begin
            word_checks++;
            if (rx_q.size() == 0) begin
                word_errors++;
                $display("%s: net_rx delivered a word that no frame accounts for", test_name);
            end else begin
                rx_exp = rx_q.pop_front();
                if (net_rx_word !== rx_exp) begin
                    word_errors++;
                    $display("error %s expected %h actual %h", test_name, rx_exp, net_rx_word);
                end
            end
        end
        if (mac_tx_valid && mac_tx_ready) begin
            word_checks++;
            if (tx_q.size() == 0) begin
                word_errors++;
                $display("%s: mac_tx delivered a word that no frame accounts for", test_name);
            end else begin
                tx_exp = tx_q.pop_front();
                if (mac_tx_word !== tx_exp) begin
                    word_errors++;
                    $display("error %s expected %h actual %h", test_name, tx_exp, mac_tx_word);
                end
            end
        end
    end

    always @(posedge sys_reset) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles in %s", MAX_CYCLES, test_name);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'he9d7_edb7));
        net_clk      = 1'b1;
        mac_rx_reset = 1'b1;
        mac_tx_reset = 1'b1;
        mac_rx_valid = 1'b0;
        mac_rx_word  = '0;
        mac_rx_bad   = 1'b0;
        net_tx_valid = 1'b0;
        net_tx_word  = '0;

        test_name = "init_hold";
        repeat (10) expect_init_done(1'b0);
        @(posedge sys_reset);
        net_clk <= 1'b0;
        repeat (3) expect_init_done(1'b0);  // both MAC sides still in reset
        @(posedge sys_reset);
        mac_rx_reset <= 1'b0;
        repeat (3) expect_init_done(1'b0);  // tx side still in reset
        @(posedge sys_reset);
        mac_tx_reset <= 1'b0;
        expect_init_done(1'b0);
        @(posedge sys_reset);
        expect_init_done(1'b0);             // first stage clear only
        @(posedge sys_reset);
        expect_init_done(1'b1);             // second edge with both low

        test_name = "rx_good";
        rx_ready_rand = 1'b1;
        repeat (20) rx_frame($urandom_range(1, 12), 1'b0);
        wait_drain();

        test_name = "rx_discard";
        repeat (6) begin
            rx_frame($urandom_range(1, 10), 1'b1);
            rx_frame($urandom_range(1, 10), 1'b0);
        end
        rx_frame(40, 1'b0);  // larger than the ring
        rx_frame($urandom_range(1, 10), 1'b0);
        wait_drain();

        test_name = "tx_pad";
        tx_ready_rand = 1'b1;
        for (int n = 1; n < `NET_MIN_WORDS; n++)
            tx_frame(n);
        wait_drain();

        test_name = "tx_pass";
        repeat (10) tx_frame($urandom_range(`NET_MIN_WORDS, 20));
        wait_drain();

        test_name = "init_pulse";
        @(posedge sys_reset);
        mac_tx_reset <= 1'b1;
        expect_init_done(1'b1);
        @(posedge sys_reset);
        expect_init_done(1'b1);
        @(posedge sys_reset);
        expect_init_done(1'b0);  // held again
        @(posedge sys_reset);
        mac_tx_reset <= 1'b0;
        expect_init_done(1'b0);
        @(posedge sys_reset);
        expect_init_done(1'b0);
        @(posedge sys_reset);
        expect_init_done(1'b1);

        $display("checks %0d init %0d words, errors %0d init %0d words",
                 init_checks, word_checks, init_errors, word_errors);
        if (init_errors == 0 && word_errors == 0 && word_checks > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
rtl/net_pkg.sv
rtl/net_reset_hold.sv
rtl/rx_frame_filter.sv
rtl/tx_frame_padder.sv
rtl/axis_word_fifo.sv
rtl/network_module.sv
test/network_module_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the network_module testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module network_module_tb \
    --Mdir obj_dir -o network_module_tb
out=$(./obj_dir/network_module_tb) || true
echo "$out"
echo "$out" | grep -qx "sim passed"
